// File: vlog.f
div_pkg.sv
div_ctrl_if.sv
div_fsm.sv
div_counter.sv
div_core.sv
div_result.sv
div_unit.sv
div_tb.sv

// File: Makefile
# Verilator simulation of the divide unit
# Override any variable on the command line, e.g. make run TOP=div_tb

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= ALL TESTS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: div_tb.sv
//~~~~~~~~~~~~~~~~~~~~
// Testbench for the divide unit
// Clock, reset, xorshift stimulus,
// RISC-V reference model and checks
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module div_tb
	import div_pkg::*;
();

	// Sampling edge to DIVout write
	localparam int LATENCY = 34;
	// Cycle limit of every wait loop
	localparam int WAIT_LIMIT = 100;
	localparam int N_RANDOM = 300;
	localparam int N_BUSY = 20;
	localparam word_t MIN_INT = 32'h8000_0000;
	localparam word_t ALL_ONES = 32'hffff_ffff;

	logic    CLK;
	logic    nrst;
	word_t   opA;
	word_t   opB;
	logic    div_valid;
	div_op_t div_op;
	logic    div_running;
	word_t   DIVout;

	logic [31:0] rng_state;
	// Dividends tried against a zero divisor
	word_t zero_cases [5];

	div_unit div_unit_i (
		.CLK         (CLK),
		.nrst        (nrst),
		.opA         (opA),
		.opB         (opB),
		.div_valid   (div_valid),
		.div_op      (div_op),
		.div_running (div_running),
		.DIVout      (DIVout)
	);

	// 10 ns clock
	always #5 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_random(output logic [31:0] v);
		rng_state = xorshift32(rng_state);
		v = rng_state;
	endtask

	// Edge values a quarter of the time, otherwise random with a random shift
	task automatic pick_operand(output word_t v);
		logic [31:0] r;
		logic [31:0] w;
		draw_random(r);
		draw_random(w);
		if (r[1:0] == 2'd0) begin
			case (r[3:2])
				2'd0:    v = 32'd0;
				2'd1:    v = 32'd1;
				2'd2:    v = ALL_ONES;
				default: v = MIN_INT;
			endcase
		end else if (r[7]) begin
			// Small values give long quotients
			v = w >> r[12:8];
		end else begin
			v = w;
		end
	endtask

	// RISC-V M-extension result
	function automatic word_t model_result(input div_op_t op, input word_t a, input word_t b);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		logic               ovf;
		word_t              r;
		sa = a;
		sb = b;
		ovf = (a == MIN_INT) && (b == ALL_ONES);
		case (op)
			OP_DIV: begin
				if (b == '0) r = ALL_ONES;
				else if (ovf) r = MIN_INT;
				else r = sa / sb;
			end
			OP_DIVU: r = (b == '0) ? ALL_ONES : a / b;
			OP_REM: begin
				// Sign of the remainder follows the dividend
				if (b == '0) r = a;
				else if (ovf) r = 32'd0;
				else r = sa % sb;
			end
			default: r = (b == '0) ? a : a % b;
		endcase
		return r;
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("CHECK FAILED at time %0t: %s = %h, expected %h", $time, name, got, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("TIMEOUT at time %0t: gave up waiting for %s", $time, what);
		$display("SOME TESTS FAILED");
		$fatal(1, "a wait loop ran out of cycles");
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (div_running) begin
			if (waited >= WAIT_LIMIT) begin
				report_timeout("div_running to drop before a new operation");
			end else begin
				@(negedge CLK);
				waited++;
			end
		end
	endtask

	// Issue one operation, optionally with strobes while busy
	task automatic run_op(input div_op_t op, input word_t a, input word_t b, input bit noisy);
		word_t       expected;
		word_t       prev;
		logic [31:0] r;
		int          cycles;
		expected = model_result(op, a, b);
		wait_idle();
		prev = DIVout;
		opA = a;
		opB = b;
		div_op = op;
		div_valid = 1'b1;
		// Stall request rises combinationally in the sampling cycle
		#1;
		check_value("div_running", word_t'(div_running), 32'd1);
		// This negedge follows the sampling edge
		@(negedge CLK);
		div_valid = 1'b0;
		cycles = 0;
		while (div_running) begin
			if (cycles >= WAIT_LIMIT) begin
				report_timeout("div_running to drop after an operation was issued");
			end else begin
				// Old result holds until the new one is written
				check_value("DIVout", DIVout, prev);
				if (noisy && cycles < LATENCY - 4) begin
					// Unit is busy, these must be ignored
					pick_operand(opA);
					pick_operand(opB);
					draw_random(r);
					div_op = r[1:0];
					div_valid = r[2];
				end else begin
					div_valid = 1'b0;
				end
				@(negedge CLK);
				cycles++;
			end
		end
		check_value("latency", word_t'(cycles), word_t'(LATENCY));
		check_value("DIVout", DIVout, expected);
	endtask

	// Idle cycles with moving operands, DIVout must hold
	task automatic hold_idle(input int n);
		word_t       held;
		logic [31:0] r;
		held = DIVout;
		for (int i = 0; i < n; i++) begin
			pick_operand(opA);
			pick_operand(opB);
			draw_random(r);
			div_op = r[1:0];
			@(negedge CLK);
			check_value("DIVout", DIVout, held);
			check_value("div_running", word_t'(div_running), 32'd0);
		end
	endtask

	initial begin
		logic [31:0] r;
		word_t       a;
		word_t       b;
		div_op_t     op_sel;
		CLK = 1'b0;
		nrst = 1'b0;
		opA = '0;
		opB = '0;
		div_op = OP_DIV;
		div_valid = 1'b0;
		rng_state = 32'he1eb_e5dd;
		zero_cases[0] = 32'd0;
		zero_cases[1] = 32'd1;
		zero_cases[2] = 32'h1234_5678;
		zero_cases[3] = MIN_INT;
		zero_cases[4] = ALL_ONES;

		// Reset for two cycles
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		check_value("div_running", word_t'(div_running), 32'd0);
		check_value("DIVout", DIVout, 32'd0);
		nrst = 1'b1;

		// Divide by zero, all ops
		foreach (zero_cases[i]) begin
			for (int k = 0; k < 4; k++) begin
				op_sel = div_op_t'(k);
				run_op(op_sel, zero_cases[i], 32'd0, 1'b0);
				if (op_sel == OP_DIV || op_sel == OP_DIVU) begin
					check_value("DIVout", DIVout, ALL_ONES);
				end else begin
					check_value("DIVout", DIVout, zero_cases[i]);
				end
			end
		end

		// Most negative by minus one, signed and unsigned
		run_op(OP_DIV, MIN_INT, ALL_ONES, 1'b0);
		check_value("DIVout", DIVout, MIN_INT);
		run_op(OP_REM, MIN_INT, ALL_ONES, 1'b0);
		check_value("DIVout", DIVout, 32'd0);
		run_op(OP_DIVU, MIN_INT, ALL_ONES, 1'b0);
		check_value("DIVout", DIVout, 32'd0);
		run_op(OP_REMU, MIN_INT, ALL_ONES, 1'b0);
		check_value("DIVout", DIVout, MIN_INT);

		// Random ops with short idle gaps
		for (int n = 0; n < N_RANDOM; n++) begin
			pick_operand(a);
			pick_operand(b);
			draw_random(r);
			run_op(div_op_t'(r[1:0]), a, b, 1'b0);
			hold_idle(int'(r[3:2]));
		end

		// Strobes while busy
		for (int n = 0; n < N_BUSY; n++) begin
			pick_operand(a);
			pick_operand(b);
			draw_random(r);
			run_op(div_op_t'(r[1:0]), a, b, 1'b1);
			hold_idle(3);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: div_unit.sv
//~~~~~~~~~~~~~~~~~~~~
// Integer divide unit top level
// FSM, counter, datapath and result stage
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module div_unit
	import div_pkg::*;
(
	input  wire     CLK,
	input  wire     nrst,
	input  word_t   opA,
	input  word_t   opB,
	input  wire     div_valid,
	input  div_op_t div_op,
	output logic    div_running,
	output word_t   DIVout
);

	// Magnitudes from the datapath
	word_t quot_mag;
	word_t rem_mag;

	// Internal strobes
	div_ctrl_if ctl_if ();

	div_fsm fsm_i (
		.CLK         (CLK),
		.nrst        (nrst),
		.div_valid   (div_valid),
		.div_running (div_running),
		.ctl         (ctl_if.fsm)
	);

	div_counter counter_i (
		.CLK  (CLK),
		.nrst (nrst),
		.ctl  (ctl_if.counter)
	);

	div_core core_i (
		.CLK      (CLK),
		.nrst     (nrst),
		.opA      (opA),
		.opB      (opB),
		.div_op   (div_op),
		.ctl      (ctl_if.core),
		.quot_mag (quot_mag),
		.rem_mag  (rem_mag)
	);

	// Sees the same raw operands for sign and zero capture
	div_result result_i (
		.CLK      (CLK),
		.nrst     (nrst),
		.opA      (opA),
		.opB      (opB),
		.div_op   (div_op),
		.ctl      (ctl_if.result),
		.quot_mag (quot_mag),
		.rem_mag  (rem_mag),
		.DIVout   (DIVout)
	);

endmodule

`default_nettype wire

// File: div_result.sv
//~~~~~~~~~~~~~~~~~~~~
// Result stage
// Sign fix, divide by zero, DIVout register
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module div_result
	import div_pkg::*;
(
	input  wire     CLK,
	input  wire     nrst,
	input  word_t   opA,
	input  word_t   opB,
	input  div_op_t div_op,
	div_ctrl_if.result ctl,
	input  word_t   quot_mag,
	input  word_t   rem_mag,
	output word_t   DIVout
);

	logic is_signed;

	// Captured with the operands
	div_op_t op_q;
	logic    neg_quo_q;
	logic    neg_rem_q;
	logic    zero_q;

	// Corrected candidates
	word_t quo_fix;
	word_t rem_fix;
	word_t res;

	assign is_signed = (div_op == OP_DIV) || (div_op == OP_REM);

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			op_q      <= OP_DIV;
			neg_quo_q <= 1'b0;
			neg_rem_q <= 1'b0;
			zero_q    <= 1'b0;
		end else if (ctl.start) begin
			op_q      <= div_op;
			// Quotient negative when the signs differ
			neg_quo_q <= is_signed && (opA[WORD_W-1] ^ opB[WORD_W-1]);
			// Remainder follows the dividend
			neg_rem_q <= is_signed && opA[WORD_W-1];
			zero_q    <= (opB == '0);
		end
	end

	assign quo_fix = neg_quo_q ? -quot_mag : quot_mag;
	// With a zero divisor this restores the original dividend
	assign rem_fix = neg_rem_q ? -rem_mag : rem_mag;

	always_comb begin
		case (op_q)
			OP_DIV, OP_DIVU: res = zero_q ? '1 : quo_fix;
			default:         res = rem_fix;
		endcase
	end

	// Held until the next operation finishes
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			DIVout <= '0;
		end else if (ctl.finish) begin
			DIVout <= res;
		end
	end

endmodule

`default_nettype wire

// File: div_core.sv
//~~~~~~~~~~~~~~~~~~~~
// Radix-2 restoring divider
// Works on operand magnitudes, sign fixed later
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module div_core
	import div_pkg::*;
(
	input  wire     CLK,
	input  wire     nrst,
	input  word_t   opA,
	input  word_t   opB,
	input  div_op_t div_op,
	div_ctrl_if.core ctl,
	output word_t   quot_mag,
	output word_t   rem_mag
);

	// DIV and REM take two's complement operands
	logic is_signed;

	// Operand magnitudes
	word_t mag_a;
	word_t mag_b;

	// Partial remainder
	word_t rem_q;
	// Dividend bits shift out the top, quotient bits shift in below
	word_t quo_q;
	// Divisor magnitude
	word_t dsr_q;

	// Shifted remainder and trial difference, one bit wider for the borrow
	logic [WORD_W:0] shifted;
	logic [WORD_W:0] trial;
	logic            fits;

	assign is_signed = (div_op == OP_DIV) || (div_op == OP_REM);

	// Absolute values
	// 32'h8000_0000 stays as is, which is its correct unsigned magnitude
	assign mag_a = (is_signed && opA[WORD_W-1]) ? -opA : opA;
	assign mag_b = (is_signed && opB[WORD_W-1]) ? -opB : opB;

	// One restoring step
	always_comb begin
		shifted = {rem_q, quo_q[WORD_W-1]};
		trial   = shifted - {1'b0, dsr_q};
		// No borrow means the divisor fits
		// Always true for a zero divisor, giving all ones and rem = dividend
		fits    = ~trial[WORD_W];
	end

	// Remainder and quotient/dividend shift register
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			rem_q <= '0;
			quo_q <= '0;
		end else if (ctl.start) begin
			rem_q <= '0;
			quo_q <= mag_a;
		end else if (ctl.step) begin
			// Restore by keeping the shifted value when the subtract would go negative
			rem_q <= fits ? trial[WORD_W-1:0] : shifted[WORD_W-1:0];
			quo_q <= {quo_q[WORD_W-2:0], fits};
		end
	end

	// Divisor holds for the whole operation
	always_ff @(posedge CLK) begin
		if (ctl.start) begin
			dsr_q <= mag_b;
		end
	end

	// Valid from the edge that applies the last step
	assign quot_mag = quo_q;
	assign rem_mag  = rem_q;

endmodule

`default_nettype wire

// File: div_counter.sv
//~~~~~~~~~~~~~~~~~~~~
// Iteration counter
// Flags the final shift-subtract step
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module div_counter
	import div_pkg::*;
(
	input wire CLK,
	input wire nrst,
	div_ctrl_if.counter ctl
);

	// Reload value, so step n runs with count 32-n
	localparam cnt_t CNT_INIT = cnt_t'(DIV_STEPS - 1);

	cnt_t cnt;

	// Down counter
	// Reset to the reload value keeps last low while idle
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			cnt <= CNT_INIT;
		end else if (ctl.clear) begin
			cnt <= CNT_INIT;
		end else if (ctl.step) begin
			// Wraps back to CNT_INIT after the last step
			cnt <= cnt - cnt_t'(1);
		end
	end

	// Count of zero marks the 32nd step
	assign ctl.last = (cnt == '0);

endmodule

`default_nettype wire

// File: div_fsm.sv
//~~~~~~~~~~~~~~~~~~~~
// Divide sequencer FSM
// Decodes the control strobes and div_running
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module div_fsm
	import div_pkg::*;
(
	input  wire  CLK,
	input  wire  nrst,
	input  wire  div_valid,
	output logic div_running,
	div_ctrl_if.fsm ctl
);

	div_state_t state;
	div_state_t state_nxt;

	// Strobe accepted only from idle
	logic accept;

	assign accept = (state == ST_IDLE) && div_valid;

	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				// Busy strobes never reach here, they are ignored
				if (div_valid) begin
					state_nxt = ST_PREP;
				end
			end
			ST_PREP: begin
				state_nxt = ST_ITER;
			end
			ST_ITER: begin
				// Leave after the 32nd step
				if (ctl.last) begin
					state_nxt = ST_FIX;
				end
			end
			ST_FIX: begin
				state_nxt = ST_IDLE;
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	// State register
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Operands are latched on the sampling edge itself,
	// the pipeline may move opA/opB once stalled
	assign ctl.start = accept;

	// Counter reload in the cycle before the first step
	assign ctl.clear = (state == ST_PREP);

	// One iteration per ITER cycle
	assign ctl.step = (state == ST_ITER);

	// DIVout written on the edge that leaves FIX
	assign ctl.finish = (state == ST_FIX);

	// Stall request
	// Raised combinationally in the sampling cycle so the pipeline
	// holds the divide in EX, then kept up until DIVout is written
	assign div_running = accept || (state != ST_IDLE);

endmodule

`default_nettype wire

// File: div_ctrl_if.sv
//~~~~~~~~~~~~~~~~~~~~
// Control strobes between the FSM,
// the iteration counter and the data blocks
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface div_ctrl_if;

	// Operand latch strobe, one cycle
	logic start;
	// One restoring iteration per cycle while high
	logic step;
	// Final iteration flag from the counter
	logic last;
	// Result write strobe, one cycle
	logic finish;
	// Counter reload
	logic clear;

	// Sequencer drives all strobes and watches last
	modport fsm (
		output start, step, finish, clear,
		input  last
	);

	// Counter only sees reload and advance
	modport counter (
		input  clear, step,
		output last
	);

	modport core (
		input start, step
	);

	modport result (
		input start, finish
	);

endinterface

`default_nettype wire

// File: div_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the divide unit
// Word and count types, op codes, FSM states
//~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package div_pkg;

	// Datapath width, fixed by the ISA
	localparam int WORD_W = 32;

	// Number of shift-subtract iterations, one per quotient bit
	localparam int DIV_STEPS = 32;

	// Operands, quotient, remainder and DIVout
	typedef logic [WORD_W-1:0] word_t;

	// M-extension divide op code
	typedef logic [1:0] div_op_t;

	// Iteration index, counts down to zero
	typedef logic [4:0] cnt_t;

	// Op encoding as used by the core's decode stage
	localparam div_op_t OP_DIV  = 2'd0;
	localparam div_op_t OP_DIVU = 2'd1;
	localparam div_op_t OP_REM  = 2'd2;
	localparam div_op_t OP_REMU = 2'd3;

	// Sequencer states
	// IDLE waits for div_valid
	// PREP lets the counter reload after the operands were latched
	// ITER runs the restoring iterations
	// FIX writes the corrected result to DIVout
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PREP,
		ST_ITER,
		ST_FIX
	} div_state_t;

endpackage

`default_nettype wire
